// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbMipsSystem
FILELIST  ?= mipsSystem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP), log to $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: aluUnit.sv
// 32-bit ALU with add, sub, and, or, signed slt, logical shifts and zero flag
module aluUnit import mipsPkg::*; (
  input  word_t  a,
  input  word_t  b,
  input  aluOp_t op,
  output word_t  result,
  output logic   zero
);

  // shift amount from low bits of operand a
  logic [4:0] shAmt;

  assign shAmt = a[4:0];

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // signed compare
      ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLL: result = b << shAmt;
      ALU_SRL: result = b >> shAmt;
      // ALU_NONE and anything else
      default: result = '0;
    endcase
  end

  // flag for every op, beq only looks at it after sub
  assign zero = (result == '0);

endmodule

// File: controlUnit.sv
// instruction decoder producing the control struct and the ALU operation
module controlUnit import mipsPkg::*; (
  input  opcode_t opcode,
  input  funct_t  funct,
  output ctrl_t   ctrl
);

  // single-level decode, opcode first then funct for R-type
  always_comb begin
    ctrl = '0;
    ctrl.aluOp = ALU_ADD;
    case (opcode)
      OP_RTYPE: begin
        // rd destination for all R-type
        ctrl.regDst = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          FN_ADD: ctrl.aluOp = ALU_ADD;
          FN_SUB: ctrl.aluOp = ALU_SUB;
          FN_AND: ctrl.aluOp = ALU_AND;
          FN_OR:  ctrl.aluOp = ALU_OR;
          FN_SLT: ctrl.aluOp = ALU_SLT;
          FN_SLL: begin
            ctrl.aluOp = ALU_SLL;
            ctrl.shiftOp = 1'b1;
          end
          FN_SRL: begin
            ctrl.aluOp = ALU_SRL;
            ctrl.shiftOp = 1'b1;
          end
          FN_JR: begin
            // no register result
            ctrl.regWrite = 1'b0;
            ctrl.jumpReg = 1'b1;
          end
          // unknown funct, rd gets zero
          default: ctrl.aluOp = ALU_NONE;
        endcase
      end
      OP_LW: begin
        ctrl.aluSrc = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      OP_SW: begin
        ctrl.aluSrc = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      OP_BEQ: begin
        // compare by subtract, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.aluOp = ALU_SUB;
      end
      OP_J: ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump = 1'b1;
        ctrl.link = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // unknown opcode, rt gets zero
        ctrl.aluSrc = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp = ALU_NONE;
      end
    endcase
  end

endmodule

// File: dataMem.sv
// data memory with combinational read and clocked write
module dataMem import mipsPkg::*; #(
  parameter int DMEM_DEPTH = 128
) (
  input  logic   clk,
  input  store_t req,
  output word_t  rdata
);

  localparam int IDX_W = $clog2(DMEM_DEPTH);

  word_t mem [DMEM_DEPTH];
  // byte address / 4, modulo depth
  logic [IDX_W-1:0] idx;

  assign idx = req.addr[IDX_W+1:2];

  // ========================================
  // access
  // ========================================
  // store lands at the end of the cycle
  always_ff @(posedge clk) begin
    if (req.we) begin
      mem[idx] <= req.data;
    end
  end

  // lw data back in the same cycle
  assign rdata = mem[idx];

endmodule

// File: instrMem.sv
// instruction memory with combinational fetch and clocked program-load port
module instrMem import mipsPkg::*; #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  word_t                         addr,
  output word_t                         rdata,
  input  logic                          progWe,
  input  logic [$clog2(IMEM_DEPTH)-1:0] progAddr,
  input  word_t                         progData
);

  localparam int IDX_W = $clog2(IMEM_DEPTH);

  word_t mem [IMEM_DEPTH];
  // word index, upper pc bits wrap around
  logic [IDX_W-1:0] fetchIdx;

  assign fetchIdx = addr[IDX_W+1:2];

  // ========================================
  // load port, used while the core is stopped
  // ========================================
  always_ff @(posedge clk) begin
    if (progWe) begin
      mem[progAddr] <= progData;
    end
  end

  // fetch within the same cycle
  assign rdata = mem[fetchIdx];

endmodule

// File: mipsCore.sv
// single-cycle datapath with decode, register file, ALU, PC and trace outputs
module mipsCore import mipsPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     run,
  output word_t    pc,
  input  word_t    instr,
  output store_t   store,
  input  word_t    rdata,
  output wbTrace_t wb
);

  localparam regAddr_t LINK_REG = 5'd31;

  ctrl_t       ctrl;
  opcode_t     opcode;
  funct_t      funct;
  regAddr_t    rs;
  regAddr_t    rt;
  regAddr_t    rd;
  regAddr_t    wAddr;
  logic [4:0]  shamt;
  logic [15:0] imm;
  logic [25:0] target;
  word_t       signExt;
  word_t       rsValue;
  word_t       rtValue;
  word_t       aluA;
  word_t       aluB;
  word_t       aluResult;
  word_t       wData;
  word_t       pcPlus4;
  logic        aluZero;
  logic        regWe;

  // ========================================
  // instruction fields
  // ========================================
  assign opcode = instr[31:26];
  assign rs = instr[25:21];
  assign rt = instr[20:16];
  assign rd = instr[15:11];
  assign shamt = instr[10:6];
  assign funct = instr[5:0];
  assign imm = instr[15:0];
  assign target = instr[25:0];
  assign signExt = {{16{imm[15]}}, imm};

  controlUnit i_controlUnit (.opcode(opcode), .funct(funct), .ctrl(ctrl));

  // writes only happen while running
  assign regWe = ctrl.regWrite & run;

  regFile i_regFile (
    .clk(clk), .rst(rst), .we(regWe),
    .rAddr1(rs), .rAddr2(rt), .wAddr(wAddr), .wData(wData),
    .rData1(rsValue), .rData2(rtValue)
  );

  // ========================================
  // operand and write-back muxes
  // ========================================
  // shifts take shamt as the amount and rt as the value
  assign aluA = ctrl.shiftOp ? {27'd0, shamt} : rsValue;
  assign aluB = ctrl.aluSrc ? signExt : rtValue;

  aluUnit i_aluUnit (.a(aluA), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .zero(aluZero));

  // jal links into r31
  assign wAddr = ctrl.link ? LINK_REG : (ctrl.regDst ? rd : rt);
  assign wData = ctrl.link ? pcPlus4 : (ctrl.memToReg ? rdata : aluResult);

  pcUnit i_pcUnit (
    .clk(clk), .rst(rst), .run(run), .ctrl(ctrl), .zero(aluZero),
    .target(target), .offset(signExt), .rsValue(rsValue),
    .pc(pc), .pcPlus4(pcPlus4)
  );

  // trace, r0 writes are dropped by the register file too
  assign wb = '{valid: regWe && (wAddr != '0), addr: wAddr, data: wData};
  // lw and sw both address by ALU result
  assign store = '{we: ctrl.memWrite & run, addr: aluResult, data: rtValue};

endmodule

// File: mipsGolden.txt
# P word | W reg(decimal) value | S byteAddr value | J pcFrom pcTo ; all other fields hex
# W and S lines in trace order, J for every pc step that is not pc+4, text after fields ignored
P 0c000001  jal 1
P 001f0880  sll r1, r31, 2
P 003f1020  add r2, r1, r31
P 03e11822  sub r3, r31, r1
P 00412024  and r4, r2, r1
P 003f2825  or r5, r1, r31
P 0061302a  slt r6, r3, r1
P 0023382a  slt r7, r1, r3
P 00034102  srl r8, r3, 4
P 00220020  add r0, r1, r2
P 00014820  add r9, r0, r1
P ac280004  sw r8, 4(r1)
P ac22fff8  sw r2, -8(r1)
P 8c4a0000  lw r10, 0(r2)
P 8c4bfff4  lw r11, -12(r2)
P 10220001  beq r1, r2, 1
P 11620001  beq r11, r2, 1
P 00216020  add r12, r1, r1
P 0c000014  jal 20
P 08000016  j 22
P 00227820  add r15, r1, r2
P 03e00008  jr r31
P ac0f0000  sw r15, 0(r0)
P 08000017  j 23
W 31 00000004
W 1 00000010
W 2 00000014
W 3 fffffff4
W 4 00000010
W 5 00000014
W 6 00000001
W 7 00000000
W 8 0fffffff
W 9 00000010
W 10 0fffffff
W 11 00000014
W 31 0000004c
W 15 00000024
S 00000014 0fffffff
S 00000008 00000014
S 00000000 00000024
J 00000040 00000048
J 00000048 00000050
J 00000054 0000004c
J 0000004c 00000058
J 0000005c 0000005c

// File: mipsPkg.sv
// shared word and field types, opcode, function and ALU codes, control, trace and store structs
package mipsPkg;

  // ========================================
  // basic widths
  // ========================================
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regAddr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [2:0]  aluOp_t;

  // primary opcodes, instr[31:26]
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  // R-type function codes, instr[5:0]
  localparam funct_t FN_SLL = 6'h00;
  localparam funct_t FN_SRL = 6'h02;
  localparam funct_t FN_JR  = 6'h08;
  localparam funct_t FN_ADD = 6'h20;
  localparam funct_t FN_SUB = 6'h22;
  localparam funct_t FN_AND = 6'h24;
  localparam funct_t FN_OR  = 6'h25;
  localparam funct_t FN_SLT = 6'h2a;

  // ALU operations
  localparam aluOp_t ALU_ADD  = 3'd0;
  localparam aluOp_t ALU_SUB  = 3'd1;
  localparam aluOp_t ALU_AND  = 3'd2;
  localparam aluOp_t ALU_OR   = 3'd3;
  localparam aluOp_t ALU_SLT  = 3'd4;
  localparam aluOp_t ALU_SLL  = 3'd5;
  localparam aluOp_t ALU_SRL  = 3'd6;
  // unknown opcode or funct, result forced to zero
  localparam aluOp_t ALU_NONE = 3'd7;

  // ========================================
  // decoded control, one per instruction
  // ========================================
  typedef struct packed {
    logic   regDst;
    logic   aluSrc;
    logic   shiftOp;
    logic   memToReg;
    logic   regWrite;
    logic   memWrite;
    logic   branch;
    logic   jump;
    logic   jumpReg;
    logic   link;
    aluOp_t aluOp;
  } ctrl_t;

  // register write-back event
  typedef struct packed {
    logic     valid;
    regAddr_t addr;
    word_t    data;
  } wbTrace_t;

  // data memory request, addr is a byte address
  typedef struct packed {
    logic  we;
    word_t addr;
    word_t data;
  } store_t;

endpackage

// File: mipsSystem.f
mipsPkg.sv
controlUnit.sv
aluUnit.sv
regFile.sv
pcUnit.sv
mipsCore.sv
instrMem.sv
dataMem.sv
mipsSystem.sv
tbMipsSystem.sv

// File: mipsSystem.sv
// top level with core, instruction memory and data memory
module mipsSystem import mipsPkg::*; #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 128
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          run,
  input  logic                          progWe,
  input  logic [$clog2(IMEM_DEPTH)-1:0] progAddr,
  input  word_t                         progData,
  output word_t                         pc,
  output wbTrace_t                      wb,
  output store_t                        store
);

  // fetch path
  word_t instr;
  // load data path
  word_t dmemRdata;

  mipsCore i_mipsCore (
    .clk(clk),
    .rst(rst),
    .run(run),
    .pc(pc),
    .instr(instr),
    .store(store),
    .rdata(dmemRdata),
    .wb(wb)
  );

  instrMem #(.IMEM_DEPTH(IMEM_DEPTH)) i_instrMem (
    .clk(clk),
    .addr(pc),
    .rdata(instr),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData)
  );

  dataMem #(.DMEM_DEPTH(DMEM_DEPTH)) i_dataMem (
    .clk(clk),
    .req(store),
    .rdata(dmemRdata)
  );

endmodule

// File: pcUnit.sv
// program counter register and next-PC selection
module pcUnit import mipsPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        run,
  input  ctrl_t       ctrl,
  input  logic        zero,
  input  logic [25:0] target,
  input  word_t       offset,
  input  word_t       rsValue,
  output word_t       pc,
  output word_t       pcPlus4
);

  word_t pcReg;
  word_t nextPc;
  word_t branchPc;
  word_t jumpPc;

  assign pcPlus4 = pcReg + 32'd4;
  // word offset to byte offset
  assign branchPc = pcPlus4 + {offset[29:0], 2'b00};
  // region bits from pc+4
  assign jumpPc = {pcPlus4[31:28], target, 2'b00};

  // jr beats j beats taken beq
  always_comb begin
    if (ctrl.jumpReg) begin
      nextPc = rsValue;
    end else if (ctrl.jump) begin
      nextPc = jumpPc;
    end else if (ctrl.branch && zero) begin
      nextPc = branchPc;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // hold while stopped
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else if (run) begin
      pcReg <= nextPc;
    end
  end

  assign pc = pcReg;

endmodule

// File: regFile.sv
// 32x32 register file, two combinational reads, one clocked write, r0 fixed at zero
module regFile import mipsPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     we,
  input  regAddr_t rAddr1,
  input  regAddr_t rAddr2,
  input  regAddr_t wAddr,
  input  word_t    wData,
  output word_t    rData1,
  output word_t    rData2
);

  // r0 is not stored
  word_t regs [1:31];

  // ========================================
  // write port
  // ========================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wAddr != '0)) begin
      regs[wAddr] <= wData;
    end
  end

  // ========================================
  // read ports
  // ========================================
  // no bypass, a write shows up next cycle
  assign rData1 = (rAddr1 == '0) ? '0 : regs[rAddr1];
  assign rData2 = (rAddr2 == '0) ? '0 : regs[rAddr2];

endmodule

// File: tbMipsSystem.sv
// testbench for mipsSystem with golden program load, stall checks, trace and pc-flow compare
module tbMipsSystem import mipsPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 128;
  localparam int PROG_AW = $clog2(IMEM_DEPTH);
  localparam int CLK_PERIOD = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int RUN_TIMEOUT = 200;
  localparam int WATCHDOG_NS = 50000;
  localparam int NUM_TESTS = 4;
  localparam int T_STALL = 0;
  localparam int T_WB = 1;
  localparam int T_STORE = 2;
  localparam int T_FLOW = 3;
  localparam string GOLDEN_FILE = "mipsGolden.txt";

  logic clk = 1'b0;
  logic rst;
  logic run;
  logic progWe;
  logic [PROG_AW-1:0] progAddr;
  word_t progData;
  word_t pc;
  wbTrace_t wb;
  store_t store;

  // golden entries with two fields packed per entry
  word_t progQ[$];
  logic [63:0] wbQ[$];
  logic [63:0] stQ[$];
  logic [63:0] jmpQ[$];
  int wbIdx = 0;
  int stIdx = 0;
  int jmpIdx = 0;
  string testName[NUM_TESTS] = '{"resetStall", "regWrite", "store", "pcFlow"};
  int checkCnt[NUM_TESTS];
  int errCnt[NUM_TESTS];

  always #(CLK_PERIOD / 2) clk = ~clk;

  mipsSystem #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) i_mipsSystem (
    .clk(clk), .rst(rst), .run(run),
    .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .pc(pc), .wb(wb), .store(store)
  );

  // ========================================
  // check helpers
  // ========================================
  task automatic checkTrue(input int test, input bit cond, input string msg);
    checkCnt[test]++;
    assert (cond) else begin
      errCnt[test]++;
      $display("ERROR %s: %s", testName[test], msg);
    end
  endtask

  task automatic compareWord(input int test, input string what, input word_t expVal,
                             input word_t actVal);
    checkCnt[test]++;
    assert (actVal === expVal) else begin
      errCnt[test]++;
      $display("MISMATCH %s %s expected %08h actual %08h", testName[test], what, expVal, actVal);
    end
  endtask

  // next golden entry against an observed event
  task automatic matchEvent(input int test, input int idx, input bit have,
                            input logic [63:0] expEntry, input string nameA, input string nameB,
                            input word_t a, input word_t b);
    if (have) begin
      compareWord(test, $sformatf("event %0d %s", idx, nameA), expEntry[63:32], a);
      compareWord(test, $sformatf("event %0d %s", idx, nameB), expEntry[31:0], b);
    end else begin
      checkTrue(test, 1'b0, $sformatf("unexpected extra event %s %08h %s %08h",
                                      nameA, a, nameB, b));
    end
  endtask

  task automatic finishTest(input int test);
    $display("test %s: %0d checks, %0d errors", testName[test], checkCnt[test], errCnt[test]);
  endtask

  task automatic readGolden();
    int fd;
    int r;
    string line;
    word_t a;
    word_t b;
    fd = $fopen(GOLDEN_FILE, "r");
    checkTrue(T_STALL, fd != 0, {"cannot open ", GOLDEN_FILE});
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        // first char picks the line kind and comment lines fall to default
        case (line.getc(0))
          "P": begin
            r = $sscanf(line, "P %h", a);
            checkTrue(T_STALL, r == 1, "malformed program line in golden file");
            progQ.push_back(a);
          end
          "W": begin
            r = $sscanf(line, "W %d %h", a, b);
            checkTrue(T_STALL, r == 2, "malformed register write line in golden file");
            wbQ.push_back({a, b});
          end
          "S": begin
            r = $sscanf(line, "S %h %h", a, b);
            checkTrue(T_STALL, r == 2, "malformed store line in golden file");
            stQ.push_back({a, b});
          end
          "J": begin
            r = $sscanf(line, "J %h %h", a, b);
            checkTrue(T_STALL, r == 2, "malformed pc jump line in golden file");
            jmpQ.push_back({a, b});
          end
          default: ;
        endcase
      end
      $fclose(fd);
    end
    checkTrue(T_STALL, progQ.size() > 0, "golden file holds no program");
  endtask

  // one stopped cycle sampled at the falling edge
  task automatic stallCycle();
    @(negedge clk);
    compareWord(T_STALL, "pc", '0, pc);
    compareWord(T_STALL, "wb.valid", '0, word_t'(wb.valid));
    compareWord(T_STALL, "store.we", '0, word_t'(store.we));
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    int idle;
    int cycles;
    int totalChecks;
    int totalErrors;
    bit first;
    bit done;
    word_t lastPc;
    void'($urandom(60));
    rst = 1'b0;
    run = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    readGolden();
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b1;
    idle = $urandom_range(4, 1);
    repeat (idle) stallCycle();
    // program load with one word per cycle
    foreach (progQ[i]) begin
      progWe = 1'b1;
      progAddr = PROG_AW'(i);
      progData = progQ[i];
      stallCycle();
    end
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    idle = $urandom_range(6, 1);
    repeat (idle) stallCycle();
    finishTest(T_STALL);
    run = 1'b1;
    first = 1'b1;
    done = 1'b0;
    cycles = 0;
    lastPc = '0;
    // run until the pc repeats (j to itself)
    while (!done && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (!first && pc != lastPc + 32'd4) begin
        matchEvent(T_FLOW, jmpIdx, jmpIdx < jmpQ.size(), jmpIdx < jmpQ.size() ? jmpQ[jmpIdx] : '0,
                   "from", "to", lastPc, pc);
        jmpIdx++;
      end
      if (wb.valid) begin
        matchEvent(T_WB, wbIdx, wbIdx < wbQ.size(), wbIdx < wbQ.size() ? wbQ[wbIdx] : '0,
                   "reg", "data", word_t'(wb.addr), wb.data);
        wbIdx++;
      end
      if (store.we) begin
        matchEvent(T_STORE, stIdx, stIdx < stQ.size(), stIdx < stQ.size() ? stQ[stIdx] : '0,
                   "addr", "data", store.addr, store.data);
        stIdx++;
      end
      done = !first && (pc == lastPc);
      first = 1'b0;
      lastPc = pc;
    end
    checkTrue(T_FLOW, done, $sformatf("pc did not reach its end loop in %0d cycles", RUN_TIMEOUT));
    checkTrue(T_FLOW, jmpIdx == jmpQ.size(),
              $sformatf("%0d pc jumps expected, %0d seen", jmpQ.size(), jmpIdx));
    checkTrue(T_WB, wbIdx == wbQ.size(),
              $sformatf("%0d register writes expected, %0d seen", wbQ.size(), wbIdx));
    checkTrue(T_STORE, stIdx == stQ.size(),
              $sformatf("%0d stores expected, %0d seen", stQ.size(), stIdx));
    finishTest(T_WB);
    finishTest(T_STORE);
    finishTest(T_FLOW);
    totalChecks = 0;
    totalErrors = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      totalChecks += checkCnt[t];
      totalErrors += errCnt[t];
    end
    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, totalChecks, totalErrors);
    if (totalErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // overall limit in case a clock wait never returns
  initial begin
    #WATCHDOG_NS;
    $display("ERROR simulation ran past the watchdog limit");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
